/* pe_cntl_cfg.svh */
`ifndef PE_CNTL_CFG_SVH
`define PE_CNTL_CFG_SVH

// output positions handled per window
`define PE_LANES 4

// filter sub-blocks per kernel pass
`define PE_KC 2

// spatial coordinate width, covers sizes up to 15
`define PE_COORD_W 4

// kernel tap index and kernel size width
`define PE_KERN_W 2

// channel and filter index or count width
`define PE_CHAN_W 3

// convolution stride width
`define PE_STRIDE_W 2

`endif

/* pe_cntl_pkg.sv */
`include "pe_cntl_cfg.svh"

package pe_cntl_pkg;

    // plain vector types
    typedef logic [`PE_COORD_W-1:0]       coord_t;
    typedef logic [`PE_KERN_W-1:0]        kern_t;
    typedef logic [`PE_CHAN_W-1:0]        chan_t;
    typedef logic [$clog2(`PE_KC)-1:0]    kc_t;
    typedef logic [`PE_STRIDE_W-1:0]      stride_t;

    // one output position of a lane
    typedef struct packed {
        coord_t w;
        coord_t h;
        logic   valid;
    } pos_t;

    // all lane positions of one window, lane 0 first
    typedef struct packed {
        pos_t [`PE_LANES-1:0] lane;
    } window_t;

    // layer shape, true sizes
    typedef struct packed {
        coord_t  size_w;
        coord_t  size_h;
        kern_t   size_r;
        kern_t   size_s;
        stride_t stride;
        chan_t   num_c;
        chan_t   num_k;
    } layer_cfg_t;

    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_STREAM  = 3'd1,
        ST_EXECUTE = 3'd2,
        ST_PPU     = 3'd3,
        ST_DONE    = 3'd4
    } pe_state_t;

    // loop position of the current compute step
    typedef struct packed {
        pe_state_t state;
        chan_t     k;
        chan_t     c;
        kc_t       kc;
        kern_t     r;
        kern_t     s;
        window_t   window;
    } pe_status_t;

endpackage

/* pe_cntl_properties.sv */
`timescale 1ns/100ps

module pe_cntl_properties (
    input logic                    clk,
    input logic                    rst,
    input logic                    busy,
    input logic                    step,
    input logic                    req_input,
    input pe_cntl_pkg::pe_status_t status
);

    // input stream only requested while streaming
    a_req_input_stream: assert property (
        @(posedge clk) disable iff (rst) req_input |-> status.state == pe_cntl_pkg::ST_STREAM
    ) else $error("req_input high outside the stream phase");

    // busy stalls every compute step
    a_step_not_busy: assert property (
        @(posedge clk) disable iff (rst) step |-> !busy
    ) else $error("step raised while busy");

    // a step always covers at least one output position
    a_lane0_valid: assert property (
        @(posedge clk) disable iff (rst) step |-> status.window.lane[0].valid
    ) else $error("step with an invalid first lane");

endmodule

/* pe_cntl_tb.sv */
`timescale 1ns/100ps
`include "pe_cntl_cfg.svh"

module pe_cntl_tb;

    localparam int NUM_LAYERS = 6;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    start;
    pe_cntl_pkg::layer_cfg_t layer_cfg;
    logic                    busy;
    logic                    filter_done;
    logic                    input_done;
    logic                    ppu_done;
    logic                    req_filter;
    logic                    req_input;
    logic                    step;
    logic                    done;
    pe_cntl_pkg::pe_status_t status;

    pe_cntl_pkg::pe_status_t exp_q[$];
    pe_cntl_pkg::pe_status_t exp_status;
    pe_cntl_pkg::pe_status_t snap_status;
    pe_cntl_pkg::layer_cfg_t cfgs[NUM_LAYERS];
    logic                    snap_req_filter;
    logic                    snap_req_input;
    logic                    snap_done;
    int                      layer_steps[NUM_LAYERS];
    int                      step_count = 0;
    int                      err_count = 0;
    int                      cycle_count = 0;
    int                      cycle_limit = 0;

    pe_cntl_top u_dut (.*);

    bind pe_cntl_top pe_cntl_properties u_properties (
        .clk(clk), .rst(rst), .busy(busy), .step(step), .req_input(req_input), .status(status)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, layer did not finish", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic record_failure(input string msg);
        $display("%s", msg);
        err_count++;
    endtask

    // next output position under stride and limits with h moving first
    function automatic pe_cntl_pkg::pos_t step_position(pe_cntl_pkg::pos_t p, int lw, int lh,
                                                        int st);
        pe_cntl_pkg::pos_t n;
        n = '0;
        if (p.valid && int'(p.h) + st <= lh) begin
            n.w = p.w;
            n.h = pe_cntl_pkg::coord_t'(int'(p.h) + st);
            n.valid = 1'b1;
        end else if (p.valid && int'(p.w) + st <= lw) begin
            n.w = pe_cntl_pkg::coord_t'(int'(p.w) + st);
            n.valid = 1'b1;
        end
        return n;
    endfunction

    // w and h of an invalid lane carry no meaning
    function automatic pe_cntl_pkg::pe_status_t mask_invalid(pe_cntl_pkg::pe_status_t st);
        pe_cntl_pkg::pe_status_t m;
        m = st;
        for (int l = 0; l < `PE_LANES; l++) begin
            if (!m.window.lane[l].valid) begin
                m.window.lane[l] = '0;
            end
        end
        return m;
    endfunction

    function automatic pe_cntl_pkg::layer_cfg_t random_layer();
        pe_cntl_pkg::layer_cfg_t cfg;
        cfg.size_w = pe_cntl_pkg::coord_t'(3 + $urandom % 10);
        cfg.size_h = pe_cntl_pkg::coord_t'(3 + $urandom % 10);
        cfg.size_r = pe_cntl_pkg::kern_t'(1 + $urandom % 3);
        cfg.size_s = pe_cntl_pkg::kern_t'(1 + $urandom % 3);
        cfg.stride = pe_cntl_pkg::stride_t'(1 + $urandom % 2);
        cfg.num_c  = pe_cntl_pkg::chan_t'(1 + $urandom % 3);
        cfg.num_k  = pe_cntl_pkg::chan_t'(1 + $urandom % 3);
        return cfg;
    endfunction

    // expected steps ordered by k, c, window, kc, r and s
    task automatic build_layer_model(input pe_cntl_pkg::layer_cfg_t cfg, output int n);
        pe_cntl_pkg::pos_t       p;
        pe_cntl_pkg::window_t    win;
        pe_cntl_pkg::pe_status_t e;
        int                      lw;
        int                      lh;
        n  = 0;
        lw = int'(cfg.size_w) - int'(cfg.size_r);
        lh = int'(cfg.size_h) - int'(cfg.size_s);
        for (int k = 0; k < int'(cfg.num_k); k++) begin
            for (int c = 0; c < int'(cfg.num_c); c++) begin
                p = '0;
                p.valid = 1'b1;
                while (p.valid) begin
                    for (int l = 0; l < `PE_LANES; l++) begin
                        win.lane[l] = p;
                        p = step_position(p, lw, lh, int'(cfg.stride));
                    end
                    for (int kc = 0; kc < `PE_KC; kc++) begin
                        for (int r = 0; r < int'(cfg.size_r); r++) begin
                            for (int s = 0; s < int'(cfg.size_s); s++) begin
                                e = '0;
                                e.state  = pe_cntl_pkg::ST_EXECUTE;
                                e.k      = pe_cntl_pkg::chan_t'(k);
                                e.c      = pe_cntl_pkg::chan_t'(c);
                                e.kc     = pe_cntl_pkg::kc_t'(kc);
                                e.r      = pe_cntl_pkg::kern_t'(r);
                                e.s      = pe_cntl_pkg::kern_t'(s);
                                e.window = win;
                                exp_q.push_back(e);
                                n++;
                            end
                        end
                    end
                end
            end
        end
    endtask

    // sample outputs before the falling-edge drive
    task automatic next_cycle();
        @(negedge clk);
        snap_status     = status;
        snap_req_filter = req_filter;
        snap_req_input  = req_input;
        snap_done       = done;
        start           = 1'b0;
        filter_done     = 1'b0;
        input_done      = 1'b0;
        ppu_done        = 1'b0;
        busy            = ($urandom % 100) < 30;
    endtask

    task automatic wait_state(input pe_cntl_pkg::pe_state_t st);
        do next_cycle(); while (snap_status.state != st);
    endtask

    // filter_done and the other finish pulse in random order
    task automatic finish_pulses(input bit ppu_phase);
        int base_count;
        bit filter_first;
        bit filter_sent;
        base_count   = step_count;
        filter_first = ($urandom % 2) != 0;
        filter_sent  = 1'b0;
        for (int n = 0; n < 2; n++) begin
            repeat (1 + $urandom % 4) begin
                next_cycle();
                assert (filter_sent || snap_req_filter)
                    else record_failure("req_filter dropped before filter_done");
            end
            assert (step_count == base_count)
                else record_failure("step issued before both finish pulses");
            if ((n == 0) == filter_first) begin
                filter_done = 1'b1;
                filter_sent = 1'b1;
            end else if (ppu_phase) begin
                ppu_done = 1'b1;
            end else begin
                input_done = 1'b1;
            end
        end
    endtask

    // step checker sampling 10 ns ahead of the rising edge
    always @(negedge clk) begin
        #40;
        if (!rst && step) begin
            step_count++;
            assert (exp_q.size() > 0)
                else record_failure("step issued with no expected step left");
            if (exp_q.size() > 0) begin
                exp_status = exp_q.pop_front();
                assert (mask_invalid(status) == exp_status)
                    else record_failure($sformatf("FAIL status exp %h got %h", exp_status,
                                                  mask_invalid(status)));
            end
        end
    end

    initial begin
        int base_steps;
        int exp_steps;
        int errs_before;
        void'($urandom(32'h5f7c));
        rst         = 1'b1;
        start       = 1'b0;
        layer_cfg   = '0;
        busy        = 1'b0;
        filter_done = 1'b0;
        input_done  = 1'b0;
        ppu_done    = 1'b0;
        for (int i = 0; i < NUM_LAYERS; i++) begin
            cfgs[i] = random_layer();
            build_layer_model(cfgs[i], layer_steps[i]);
            cycle_limit += 4 * layer_steps[i] + 200;
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;
        repeat (4) begin
            next_cycle();
            assert (!snap_req_filter && !snap_req_input && !snap_done && step_count == 0)
                else record_failure("controller active after reset without start");
        end
        $display("test reset idle: %s", err_count == 0 ? "ok" : "errors");
        base_steps = 0;
        for (int i = 0; i < NUM_LAYERS; i++) begin
            errs_before = err_count;
            next_cycle();
            layer_cfg = cfgs[i];
            start     = 1'b1;
            next_cycle();
            assert (snap_req_filter && snap_req_input)
                else record_failure("stream requests missing after start");
            finish_pulses(1'b0);
            for (int k = 0; k < int'(cfgs[i].num_k); k++) begin
                wait_state(pe_cntl_pkg::ST_PPU);
                exp_steps = base_steps + layer_steps[i] / int'(cfgs[i].num_k) * (k + 1);
                assert (step_count == exp_steps)
                    else record_failure($sformatf("FAIL step_count exp %h got %h", exp_steps,
                                                  step_count));
                assert (snap_status.k == pe_cntl_pkg::chan_t'(k))
                    else record_failure($sformatf("FAIL status.k exp %h got %h", k,
                                                  snap_status.k));
                finish_pulses(1'b1);
            end
            wait_state(pe_cntl_pkg::ST_DONE);
            base_steps += layer_steps[i];
            repeat (3) next_cycle();
            assert (snap_done) else record_failure("done dropped after the layer ended");
            assert (step_count == base_steps)
                else record_failure($sformatf("FAIL step_count exp %h got %h", base_steps,
                                              step_count));
            $display("test layer %0d: %0d steps, %s", i, layer_steps[i],
                     err_count == errs_before ? "ok" : "errors");
        end
        $display("tests %0d, steps %0d, failed checks %0d", NUM_LAYERS + 1, step_count,
                 err_count);
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* pe_cntl_top.sv */
`timescale 1ns/100ps
`include "pe_cntl_cfg.svh"

module pe_cntl_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  pe_cntl_pkg::layer_cfg_t layer_cfg,
    input  logic                    busy,
    input  logic                    filter_done,
    input  logic                    input_done,
    input  logic                    ppu_done,
    output logic                    req_filter,
    output logic                    req_input,
    output logic                    step,
    output pe_cntl_pkg::pe_status_t status,
    output logic                    done
);

    // lane chain, entry 0 is the window base
    pe_cntl_pkg::pos_t [`PE_LANES:0] lane_pos;
    pe_cntl_pkg::pos_t               next_base;
    pe_cntl_pkg::window_t            window;
    pe_cntl_pkg::coord_t             lim_w;
    pe_cntl_pkg::coord_t             lim_h;
    pe_cntl_pkg::stride_t            stride;
    logic                            win_restart;
    logic                            win_advance;
    logic                            win_last;

    pe_sequencer u_sequencer (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .busy        (busy),
        .filter_done (filter_done),
        .input_done  (input_done),
        .ppu_done    (ppu_done),
        .num_c       (layer_cfg.num_c),
        .num_k       (layer_cfg.num_k),
        .size_r      (layer_cfg.size_r),
        .size_s      (layer_cfg.size_s),
        .window      (window),
        .win_last    (win_last),
        .win_restart (win_restart),
        .win_advance (win_advance),
        .req_filter  (req_filter),
        .req_input   (req_input),
        .step        (step),
        .done        (done),
        .status      (status)
    );

    window_base u_window_base (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .layer_cfg   (layer_cfg),
        .win_restart (win_restart),
        .win_advance (win_advance),
        .next_base   (next_base),
        .base        (lane_pos[0]),
        .lim_w       (lim_w),
        .lim_h       (lim_h),
        .stride      (stride)
    );

    // each lane steps one position past its predecessor
    for (genvar i = 0; i < `PE_LANES; i++) begin : g_lane
        window_lane u_lane (
            .prev   (lane_pos[i]),
            .lim_w  (lim_w),
            .lim_h  (lim_h),
            .stride (stride),
            .next   (lane_pos[i+1])
        );
    end

    window_collect u_window_collect (
        .lane_pos  (lane_pos),
        .window    (window),
        .next_base (next_base),
        .win_last  (win_last)
    );

endmodule

/* pe_sequencer.sv */
`timescale 1ns/100ps
`include "pe_cntl_cfg.svh"

module pe_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic                    busy,
    input  logic                    filter_done,
    input  logic                    input_done,
    input  logic                    ppu_done,
    input  pe_cntl_pkg::chan_t      num_c,
    input  pe_cntl_pkg::chan_t      num_k,
    input  pe_cntl_pkg::kern_t      size_r,
    input  pe_cntl_pkg::kern_t      size_s,
    input  pe_cntl_pkg::window_t    window,
    input  logic                    win_last,
    output logic                    win_restart,
    output logic                    win_advance,
    output logic                    req_filter,
    output logic                    req_input,
    output logic                    step,
    output logic                    done,
    output pe_cntl_pkg::pe_status_t status
);

    pe_cntl_pkg::pe_state_t state;
    pe_cntl_pkg::pe_state_t nx_state;
    pe_cntl_pkg::chan_t     k;
    pe_cntl_pkg::chan_t     nx_k;
    pe_cntl_pkg::chan_t     c;
    pe_cntl_pkg::chan_t     nx_c;
    pe_cntl_pkg::kc_t       kc;
    pe_cntl_pkg::kc_t       nx_kc;
    pe_cntl_pkg::kern_t     r;
    pe_cntl_pkg::kern_t     nx_r;
    pe_cntl_pkg::kern_t     s;
    pe_cntl_pkg::kern_t     nx_s;

    // layer bounds captured at start
    pe_cntl_pkg::chan_t     reg_num_c;
    pe_cntl_pkg::chan_t     reg_num_k;
    pe_cntl_pkg::kern_t     reg_size_r;
    pe_cntl_pkg::kern_t     reg_size_s;

    logic filter_seen;
    logic input_seen;
    logic ppu_seen;
    logic filter_hit;
    logic input_hit;
    logic ppu_hit;
    logic load_cfg;
    logic s_last;
    logic r_last;
    logic kc_last;
    logic c_last;
    logic k_last;

    // a finish pulse counts in the cycle it arrives
    assign filter_hit = filter_seen | filter_done;
    assign input_hit  = input_seen | input_done;
    assign ppu_hit    = ppu_seen | ppu_done;

    assign load_cfg = start && (state == pe_cntl_pkg::ST_IDLE || state == pe_cntl_pkg::ST_DONE);

    assign s_last  = (s == reg_size_s - 1'b1);
    assign r_last  = (r == reg_size_r - 1'b1);
    assign kc_last = (kc == pe_cntl_pkg::kc_t'(`PE_KC - 1));
    assign c_last  = (c == reg_num_c - 1'b1);
    assign k_last  = (k == reg_num_k - 1'b1);

    // busy is the only stall
    assign step       = (state == pe_cntl_pkg::ST_EXECUTE) && !busy;
    assign req_input  = (state == pe_cntl_pkg::ST_STREAM);
    assign req_filter = (state == pe_cntl_pkg::ST_STREAM) ||
                        (state == pe_cntl_pkg::ST_PPU && !filter_seen);
    assign done       = (state == pe_cntl_pkg::ST_DONE);

    always_comb begin
        status.state  = state;
        status.k      = k;
        status.c      = c;
        status.kc     = kc;
        status.r      = r;
        status.s      = s;
        status.window = window;
    end

    always_comb begin
        nx_state    = state;
        nx_k        = k;
        nx_c        = c;
        nx_kc       = kc;
        nx_r        = r;
        nx_s        = s;
        win_restart = 1'b0;
        win_advance = 1'b0;
        case (state)
            pe_cntl_pkg::ST_IDLE, pe_cntl_pkg::ST_DONE: begin
                if (start) begin
                    nx_state = pe_cntl_pkg::ST_STREAM;
                    nx_k     = '0;
                end
            end
            pe_cntl_pkg::ST_STREAM: begin
                if (filter_hit && input_hit) begin
                    nx_state    = pe_cntl_pkg::ST_EXECUTE;
                    nx_c        = '0;
                    nx_kc       = '0;
                    nx_r        = '0;
                    nx_s        = '0;
                    win_restart = 1'b1;
                end
            end
            pe_cntl_pkg::ST_EXECUTE: begin
                // s fastest, then r, kc, window, channel
                if (step) begin
                    if (!s_last) begin
                        nx_s = s + 1'b1;
                    end else begin
                        nx_s = '0;
                        if (!r_last) begin
                            nx_r = r + 1'b1;
                        end else begin
                            nx_r = '0;
                            if (!kc_last) begin
                                nx_kc = kc + 1'b1;
                            end else begin
                                nx_kc = '0;
                                if (!win_last) begin
                                    win_advance = 1'b1;
                                end else begin
                                    win_restart = 1'b1;
                                    if (!c_last) begin
                                        nx_c = c + 1'b1;
                                    end else begin
                                        // k keeps the finished filter
                                        nx_state = pe_cntl_pkg::ST_PPU;
                                    end
                                end
                            end
                        end
                    end
                end
            end
            pe_cntl_pkg::ST_PPU: begin
                if (filter_hit && ppu_hit) begin
                    if (k_last) begin
                        nx_state = pe_cntl_pkg::ST_DONE;
                    end else begin
                        nx_state    = pe_cntl_pkg::ST_EXECUTE;
                        nx_k        = k + 1'b1;
                        nx_c        = '0;
                        win_restart = 1'b1;
                    end
                end
            end
            default: begin
                nx_state = pe_cntl_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= pe_cntl_pkg::ST_IDLE;
            k           <= '0;
            c           <= '0;
            kc          <= '0;
            r           <= '0;
            s           <= '0;
            filter_seen <= 1'b0;
            input_seen  <= 1'b0;
            ppu_seen    <= 1'b0;
        end else begin
            state <= nx_state;
            k     <= nx_k;
            c     <= nx_c;
            kc    <= nx_kc;
            r     <= nx_r;
            s     <= nx_s;
            // finish flags live for one phase only
            if (nx_state != state) begin
                filter_seen <= 1'b0;
                input_seen  <= 1'b0;
                ppu_seen    <= 1'b0;
            end else begin
                if (state == pe_cntl_pkg::ST_STREAM || state == pe_cntl_pkg::ST_PPU) begin
                    filter_seen <= filter_hit;
                end
                if (state == pe_cntl_pkg::ST_STREAM) begin
                    input_seen <= input_hit;
                end
                if (state == pe_cntl_pkg::ST_PPU) begin
                    ppu_seen <= ppu_hit;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_cfg) begin
            reg_num_c  <= num_c;
            reg_num_k  <= num_k;
            reg_size_r <= size_r;
            reg_size_s <= size_s;
        end
    end

endmodule

/* project.f */
+incdir+.
pe_cntl_pkg.sv
window_lane.sv
window_base.sv
window_collect.sv
pe_sequencer.sv
pe_cntl_top.sv
pe_cntl_properties.sv
pe_cntl_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f --top-module pe_cntl_tb -o pe_cntl_sim
./obj_dir/pe_cntl_sim | tee sim.log

if grep -q "^\*\*\* TEST PASSED \*\*\*$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* window_base.sv */
`timescale 1ns/100ps

module window_base (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  pe_cntl_pkg::layer_cfg_t layer_cfg,
    input  logic                    win_restart,
    input  logic                    win_advance,
    input  pe_cntl_pkg::pos_t       next_base,
    output pe_cntl_pkg::pos_t       base,
    output pe_cntl_pkg::coord_t     lim_w,
    output pe_cntl_pkg::coord_t     lim_h,
    output pe_cntl_pkg::stride_t    stride
);

    // first position of the current window
    always_ff @(posedge clk) begin
        if (rst) begin
            base <= '0;
        end else if (win_restart) begin
            base.w     <= '0;
            base.h     <= '0;
            base.valid <= 1'b1;
        end else if (win_advance) begin
            base <= next_base;
        end
    end

    // last legal output coordinate along each axis
    always_ff @(posedge clk) begin
        if (start) begin
            lim_w  <= layer_cfg.size_w - layer_cfg.size_r;
            lim_h  <= layer_cfg.size_h - layer_cfg.size_s;
            stride <= layer_cfg.stride;
        end
    end

endmodule

/* window_collect.sv */
`timescale 1ns/100ps
`include "pe_cntl_cfg.svh"

module window_collect (
    input  pe_cntl_pkg::pos_t [`PE_LANES:0] lane_pos,
    output pe_cntl_pkg::window_t            window,
    output pe_cntl_pkg::pos_t               next_base,
    output logic                            win_last
);

    // lanes 0 .. PE_LANES-1 form the window
    always_comb begin
        for (int i = 0; i < `PE_LANES; i++) begin
            window.lane[i] = lane_pos[i];
        end
    end

    // the carry lane seeds the following window
    assign next_base = lane_pos[`PE_LANES];

    // no position left after this window
    assign win_last = !next_base.valid;

endmodule

/* window_lane.sv */
`timescale 1ns/100ps
`include "pe_cntl_cfg.svh"

module window_lane (
    input  pe_cntl_pkg::pos_t    prev,
    input  pe_cntl_pkg::coord_t  lim_w,
    input  pe_cntl_pkg::coord_t  lim_h,
    input  pe_cntl_pkg::stride_t stride,
    output pe_cntl_pkg::pos_t    next
);

    // one extra bit so the sum cannot wrap past the limit
    logic [`PE_COORD_W:0] h_step;
    logic [`PE_COORD_W:0] w_step;
    logic                 h_fits;
    logic                 w_fits;

    assign h_step = {1'b0, prev.h} + {{(`PE_COORD_W + 1 - `PE_STRIDE_W){1'b0}}, stride};
    assign w_step = {1'b0, prev.w} + {{(`PE_COORD_W + 1 - `PE_STRIDE_W){1'b0}}, stride};
    assign h_fits = (h_step <= {1'b0, lim_h});
    assign w_fits = (w_step <= {1'b0, lim_w});

    // h moves first, then wrap to the next column
    always_comb begin
        next = '0;
        if (prev.valid) begin
            if (h_fits) begin
                next.w     = prev.w;
                next.h     = h_step[`PE_COORD_W-1:0];
                next.valid = 1'b1;
            end else if (w_fits) begin
                next.w     = w_step[`PE_COORD_W-1:0];
                next.h     = '0;
                next.valid = 1'b1;
            end
        end
    end

endmodule
